// ==== rtl/tiny16_pkg.sv ====
package tiny16_pkg;

    localparam int word_bits = 16;
    localparam int ram_bits  = 12;
    localparam int reg_bits  = 4;

    // alu operations, instr[11:8]
    localparam logic [3:0] alu_adc  = 4'd0;
    localparam logic [3:0] alu_add  = 4'd1;
    localparam logic [3:0] alu_sbc  = 4'd2;
    localparam logic [3:0] alu_sub  = 4'd3;
    localparam logic [3:0] alu_cmp  = 4'd4;
    localparam logic [3:0] alu_and  = 4'd5;
    localparam logic [3:0] alu_test = 4'd6;
    localparam logic [3:0] alu_or   = 4'd7;
    localparam logic [3:0] alu_xor  = 4'd8;
    localparam logic [3:0] alu_shl  = 4'd9;
    localparam logic [3:0] alu_shr  = 4'd10;
    localparam logic [3:0] alu_rol  = 4'd11;
    localparam logic [3:0] alu_ror  = 4'd12;

    // major opcodes, instr[15:13]
    localparam logic [2:0] op_br   = 3'd0;
    localparam logic [2:0] op_jmp  = 3'd1;
    localparam logic [2:0] op_sys  = 3'd2;
    localparam logic [2:0] op_alu  = 3'd3;
    localparam logic [2:0] op_call = 3'd4;
    localparam logic [2:0] op_movi = 3'd5;

    // system group, instr[15:9]
    localparam logic [6:0] sys_halt   = 7'h20;
    localparam logic [6:0] sys_wfi    = 7'h21;
    localparam logic [6:0] sys_movrr  = 7'h22;
    localparam logic [6:0] sys_ret    = 7'h23;
    localparam logic [6:0] sys_reti   = 7'h24;
    localparam logic [6:0] sys_loadsp = 7'h25;
    localparam logic [6:0] sys_push   = 7'h26;
    localparam logic [6:0] sys_pop    = 7'h27;
    localparam logic [6:0] sys_movmr  = 7'h28;
    localparam logic [6:0] sys_movrm  = 7'h29;
    localparam logic [6:0] sys_in     = 7'h2A;
    localparam logic [6:0] sys_out    = 7'h2B;

    // write-back sources, one-hot
    localparam logic [3:0] wb_from_reg = 4'b0001;
    localparam logic [3:0] wb_from_ram = 4'b0010;
    localparam logic [3:0] wb_from_acc = 4'b0100;
    localparam logic [3:0] wb_from_in  = 4'b1000;

    // sequencer states
    localparam logic [1:0] st_fetch  = 2'd0;
    localparam logic [1:0] st_decode = 2'd1;
    localparam logic [1:0] st_exec   = 2'd2;
    localparam logic [1:0] st_result = 2'd3;

    // mov A, A
    localparam logic [word_bits-1:0] nop_word   = 16'h4400;
    localparam logic [word_bits-1:0] irq_vector = 16'h0001;

endpackage

// ==== rtl/tiny16_decode.sv ====
`timescale 1ns/1ps
module tiny16_decode
    import tiny16_pkg::*;
(
    input  logic [word_bits-1:0] instr,
    output logic                 is_br,
    output logic                 is_jmp,
    output logic                 is_call,
    output logic                 is_movi,
    output logic                 is_alu,
    output logic                 is_alui,
    output logic                 is_halt,
    output logic                 is_wfi,
    output logic                 is_movrr,
    output logic                 is_ret,
    output logic                 is_reti,
    output logic                 is_loadsp,
    output logic                 is_push,
    output logic                 is_pop,
    output logic                 is_movmr,
    output logic                 is_movrm,
    output logic                 is_in,
    output logic                 is_out,
    output logic                 result_needed,
    output logic [3:0]           alu_op,
    output logic [reg_bits-1:0]  dst_reg,
    output logic [reg_bits-1:0]  src_reg,
    output logic [reg_bits-1:0]  src_reg2,
    output logic [2:0]           cond,
    output logic                 cond_neg,
    output logic [12:0]          off13,
    output logic [8:0]           off9,
    output logic [5:0]           imm6
);
    logic [2:0] op3;
    logic [6:0] op7;
    logic       is_sys;
    logic       flags_only;

    assign op3 = instr[15:13];
    assign op7 = instr[15:9];
    assign is_sys = op3 == op_sys;

    assign is_br   = op3 == op_br;
    assign is_jmp  = op3 == op_jmp;
    assign is_alu  = op3 == op_alu;
    assign is_call = op3 == op_call;
    assign is_movi = op3 == op_movi;
    // immediate alu form takes opcodes 6 and 7
    assign is_alui = instr[15:14] == 2'b11;

    assign is_halt   = is_sys && op7 == sys_halt;
    assign is_wfi    = is_sys && op7 == sys_wfi;
    assign is_movrr  = is_sys && op7 == sys_movrr;
    assign is_ret    = is_sys && op7 == sys_ret;
    assign is_reti   = is_sys && op7 == sys_reti;
    assign is_loadsp = is_sys && op7 == sys_loadsp;
    assign is_push   = is_sys && op7 == sys_push;
    assign is_pop    = is_sys && op7 == sys_pop;
    assign is_movmr  = is_sys && op7 == sys_movmr;
    assign is_movrm  = is_sys && op7 == sys_movrm;
    assign is_in     = is_sys && op7 == sys_in;
    assign is_out    = is_sys && op7 == sys_out;

    assign alu_op   = instr[11:8];
    assign src_reg  = instr[2*reg_bits-1:reg_bits];
    assign src_reg2 = instr[reg_bits-1:0];
    assign dst_reg  = instr[reg_bits-1:0];
    assign cond     = instr[2:0];
    assign cond_neg = instr[3];
    assign off13    = instr[12:0];
    assign off9     = instr[12:4];
    // split immediate, high bits sit above the alu op
    assign imm6     = {instr[13:12], instr[7:4]};

    // cmp and test only touch the flags
    assign flags_only = alu_op == alu_cmp || alu_op == alu_test;

    assign result_needed = is_movi || is_movmr || is_pop ||
                           ((is_alu || is_alui) && !flags_only);

endmodule

// ==== rtl/tiny16_alu.sv ====
`timescale 1ns/1ps
module tiny16_alu
    import tiny16_pkg::*;
(
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 alu_en,
    input  logic [3:0]           alu_op,
    input  logic                 use_imm,
    input  logic [5:0]           imm6,
    input  logic [word_bits-1:0] reg_src,
    input  logic [word_bits-1:0] reg_src2,
    output logic [word_bits-1:0] acc,
    output logic                 carry
);
    logic [word_bits-1:0] opa;
    logic                 cin;

    assign opa = use_imm ? {{(word_bits-6){imm6[5]}}, imm6} : reg_src;

    // carry feeds adc, sbc and the rotates
    assign cin = (alu_op == alu_adc || alu_op == alu_sbc ||
                  alu_op == alu_rol || alu_op == alu_ror) ? carry : 1'b0;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            acc <= '0;
            carry <= 1'b0;
        end else if (alu_en) begin
            case (alu_op)
                alu_adc, alu_add:
                    {carry, acc} <= {1'b0, opa} + {1'b0, reg_src2} + {{word_bits{1'b0}}, cin};
                alu_sbc, alu_sub, alu_cmp:
                    {carry, acc} <= {1'b0, opa} - {1'b0, reg_src2} - {{word_bits{1'b0}}, cin};
                alu_and, alu_test:
                    acc <= opa & reg_src2;
                alu_or:
                    acc <= opa | reg_src2;
                alu_xor:
                    acc <= opa ^ reg_src2;
                alu_shl, alu_rol:
                    {carry, acc} <= {opa, cin};
                alu_shr, alu_ror:
                    {acc, carry} <= {cin, opa};
                default: ;
            endcase
        end
    end

    // decode must never hand over an unassigned op
    assert property (@(posedge clk) disable iff (!nreset) alu_en |-> alu_op <= alu_ror);

endmodule

// ==== rtl/tiny16_result.sv ====
`timescale 1ns/1ps
module tiny16_result
    import tiny16_pkg::*;
(
    input  logic                 clk,
    input  logic [reg_bits-1:0]  src_reg,
    input  logic [reg_bits-1:0]  src_reg2,
    input  logic                 wb_en,
    input  logic [reg_bits-1:0]  wb_addr,
    input  logic [3:0]           wb_sel,
    input  logic [word_bits-1:0] reg_src_in,
    input  logic [word_bits-1:0] ram_rdata,
    input  logic [word_bits-1:0] acc,
    input  logic [word_bits-1:0] data_in,
    output logic [word_bits-1:0] reg_src,
    output logic [word_bits-1:0] reg_src2
);
    logic [word_bits-1:0] regs [0:(1<<reg_bits)-1];
    logic [word_bits-1:0] wb_data;

    always_comb begin
        case (wb_sel)
            wb_from_reg: wb_data = reg_src_in;
            wb_from_ram: wb_data = ram_rdata;
            wb_from_acc: wb_data = acc;
            wb_from_in:  wb_data = data_in;
            default:     wb_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_en)
            regs[wb_addr] <= wb_data;
    end

    // read ports are combinational
    assign reg_src  = regs[src_reg];
    assign reg_src2 = regs[src_reg2];

    assert property (@(posedge clk) wb_en |-> $onehot(wb_sel));

endmodule

// ==== rtl/tiny16_core.sv ====
`timescale 1ns/1ps
module tiny16_core
    import tiny16_pkg::*;
(
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 run,
    input  logic                 interrupt,
    input  logic                 mem_ready,
    input  logic [word_bits-1:0] data_in,
    input  logic [word_bits-1:0] ram_rdata,
    output logic [ram_bits-1:0]  ram_addr,
    output logic [word_bits-1:0] ram_wdata,
    output logic                 ram_we,
    output logic [word_bits-1:0] address,
    output logic [word_bits-1:0] data_out,
    output logic                 mem_valid,
    output logic                 nwr,
    output logic                 hlt,
    output logic                 wfi,
    output logic                 in_interrupt
);
    logic [1:0]           state;
    logic [word_bits-1:0] instr;
    logic [word_bits-1:0] pc;
    logic [word_bits-1:0] sp;
    logic [word_bits-1:0] spm1;
    logic [word_bits-1:0] saved_pc;
    logic                 irq_q;

    logic is_br, is_jmp, is_call, is_movi, is_alu, is_alui;
    logic is_halt, is_wfi, is_movrr, is_ret, is_reti, is_loadsp;
    logic is_push, is_pop, is_movmr, is_movrm, is_in, is_out;
    logic result_needed;
    logic [3:0]          alu_op;
    logic [reg_bits-1:0] dst_reg;
    logic [reg_bits-1:0] src_reg;
    logic [reg_bits-1:0] src_reg2;
    logic [2:0]          cond;
    logic                cond_neg;
    logic [12:0]         off13;
    logic [8:0]          off9;
    logic [5:0]          imm6;

    logic [word_bits-1:0] reg_src;
    logic [word_bits-1:0] reg_src2;
    logic [word_bits-1:0] acc;
    logic                 carry;
    logic                 z;
    logic                 n;
    logic [2:0]           cond_hit;
    logic                 cond_pass;
    logic                 irq_enter;
    logic                 fetch_go;
    logic                 in_exec;
    logic                 in_result;
    logic                 alu_en;
    logic                 wb_en;
    logic [3:0]           wb_sel;

    tiny16_decode u_decode (
        .instr(instr),
        .is_br(is_br), .is_jmp(is_jmp), .is_call(is_call), .is_movi(is_movi),
        .is_alu(is_alu), .is_alui(is_alui), .is_halt(is_halt), .is_wfi(is_wfi),
        .is_movrr(is_movrr), .is_ret(is_ret), .is_reti(is_reti), .is_loadsp(is_loadsp),
        .is_push(is_push), .is_pop(is_pop), .is_movmr(is_movmr), .is_movrm(is_movrm),
        .is_in(is_in), .is_out(is_out), .result_needed(result_needed),
        .alu_op(alu_op), .dst_reg(dst_reg), .src_reg(src_reg), .src_reg2(src_reg2),
        .cond(cond), .cond_neg(cond_neg), .off13(off13), .off9(off9), .imm6(imm6)
    );

    tiny16_alu u_alu (
        .clk(clk), .nreset(nreset), .alu_en(alu_en), .alu_op(alu_op),
        .use_imm(is_alui), .imm6(imm6), .reg_src(reg_src), .reg_src2(reg_src2),
        .acc(acc), .carry(carry)
    );

    tiny16_result u_result (
        .clk(clk), .src_reg(src_reg), .src_reg2(src_reg2),
        .wb_en(wb_en), .wb_addr(dst_reg), .wb_sel(wb_sel), .reg_src_in(reg_src),
        .ram_rdata(ram_rdata), .acc(acc), .data_in(data_in),
        .reg_src(reg_src), .reg_src2(reg_src2)
    );

    assign z = acc == '0;
    assign n = acc[word_bits-1];
    assign cond_hit = cond & {carry, z, n};
    assign cond_pass = (|cond_hit) ^ cond_neg;

    assign spm1 = sp - 1'b1;
    assign irq_enter = irq_q && !in_interrupt;
    assign in_exec = state == st_exec;
    assign in_result = state == st_result;
    // stalls: boot load, halt, pending I/O, wfi without irq
    assign fetch_go = state == st_fetch && run && !hlt &&
                      !(mem_valid && !mem_ready) && !(wfi && !irq_q);

    assign nwr = is_in;
    assign address = reg_src;
    assign data_out = reg_src2;

    assign alu_en = in_exec && (is_alu || is_alui);
    assign ram_we = in_exec && (is_movrm || is_push || is_call);
    assign ram_wdata = is_call ? pc + 1'b1 : reg_src;

    // in data lands on the fetch that sees mem_ready
    assign wb_en = (in_exec && is_movrr) || (in_result && result_needed) ||
                   (fetch_go && mem_valid && is_in);

    always_comb begin
        if (state == st_fetch)
            wb_sel = wb_from_in;
        else if (in_exec)
            wb_sel = wb_from_reg;
        else if (is_alu || is_alui)
            wb_sel = wb_from_acc;
        else
            wb_sel = wb_from_ram;
    end

    always_comb begin
        ram_addr = pc[ram_bits-1:0];
        if (state == st_fetch && irq_enter) begin
            ram_addr = irq_vector[ram_bits-1:0];
        end else if (in_exec) begin
            if (is_ret || is_pop)
                ram_addr = sp[ram_bits-1:0];
            else if (is_movi)
                ram_addr = {{(ram_bits-9){1'b0}}, off9};
            else if (is_movmr)
                ram_addr = reg_src[ram_bits-1:0];
            else if (is_movrm)
                ram_addr = reg_src2[ram_bits-1:0];
            else if (is_call || is_push)
                ram_addr = spm1[ram_bits-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go && irq_enter)
            saved_pc <= pc;
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state <= st_fetch;
            instr <= nop_word;
            pc <= '0;
            sp <= '0;
            hlt <= 1'b0;
            wfi <= 1'b0;
            in_interrupt <= 1'b0;
            mem_valid <= 1'b0;
            irq_q <= 1'b0;
        end else begin
            irq_q <= interrupt;
            case (state)
                st_fetch: begin
                    if (fetch_go) begin
                        mem_valid <= 1'b0;
                        wfi <= 1'b0;
                        if (irq_enter) begin
                            pc <= irq_vector;
                            in_interrupt <= 1'b1;
                        end
                        state <= st_decode;
                    end
                end
                st_decode: begin
                    instr <= ram_rdata;
                    state <= st_exec;
                end
                st_exec: begin
                    // offsets are relative to this instruction
                    if (is_jmp || is_call)
                        pc <= pc + {{(word_bits-13){off13[12]}}, off13};
                    else if (is_br && cond_pass)
                        pc <= pc + {{(word_bits-9){off9[8]}}, off9};
                    else
                        pc <= pc + 1'b1;
                    if (is_call || is_push)
                        sp <= spm1;
                    else if (is_loadsp)
                        sp <= reg_src2;
                    if (is_halt)
                        hlt <= 1'b1;
                    if (is_wfi)
                        wfi <= 1'b1;
                    mem_valid <= is_in || is_out;
                    state <= (result_needed || is_ret || is_reti) ? st_result : st_fetch;
                end
                st_result: begin
                    if (is_ret) begin
                        pc <= ram_rdata;
                    end else if (is_reti) begin
                        pc <= saved_pc;
                        in_interrupt <= 1'b0;
                    end
                    if (is_ret || is_pop)
                        sp <= sp + 1'b1;
                    state <= st_fetch;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // a halted core issues no further bus cycles
    assert property (@(posedge clk) disable iff (!nreset) hlt |-> !$rose(mem_valid));

endmodule

// ==== rtl/tiny16_ram.sv ====
`timescale 1ns/1ps
module tiny16_ram
    import tiny16_pkg::*;
(
    input  logic                 clk,
    input  logic                 run,
    input  logic                 boot_we,
    input  logic [ram_bits-1:0]  boot_addr,
    input  logic [word_bits-1:0] boot_data,
    input  logic [ram_bits-1:0]  addr,
    input  logic [word_bits-1:0] wdata,
    input  logic                 we,
    output logic [word_bits-1:0] rdata
);
    logic [word_bits-1:0] mem [0:(1<<ram_bits)-1];

    always_ff @(posedge clk) begin
        if (run && we)
            mem[addr] <= wdata;
        else if (!run && boot_we)
            mem[boot_addr] <= boot_data;
        // one cycle read latency
        rdata <= mem[addr];
    end

    // core sits at fetch while the image is loaded
    assert property (@(posedge clk) we |-> run);

endmodule

// ==== rtl/tiny16_top.sv ====
`timescale 1ns/1ps
module tiny16_top
    import tiny16_pkg::*;
(
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 run,
    input  logic                 boot_we,
    input  logic [ram_bits-1:0]  boot_addr,
    input  logic [word_bits-1:0] boot_data,
    input  logic [word_bits-1:0] data_in,
    input  logic                 mem_ready,
    input  logic                 interrupt,
    output logic [word_bits-1:0] address,
    output logic [word_bits-1:0] data_out,
    output logic                 mem_valid,
    output logic                 nwr,
    output logic                 hlt,
    output logic                 wfi,
    output logic                 in_interrupt
);
    logic [ram_bits-1:0]  ram_addr;
    logic [word_bits-1:0] ram_wdata;
    logic [word_bits-1:0] ram_rdata;
    logic                 ram_we;

    tiny16_core u_core (
        .clk(clk), .nreset(nreset), .run(run), .interrupt(interrupt),
        .mem_ready(mem_ready), .data_in(data_in), .ram_rdata(ram_rdata),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
        .address(address), .data_out(data_out), .mem_valid(mem_valid), .nwr(nwr),
        .hlt(hlt), .wfi(wfi), .in_interrupt(in_interrupt)
    );

    tiny16_ram u_ram (
        .clk(clk), .run(run),
        .boot_we(boot_we), .boot_addr(boot_addr), .boot_data(boot_data),
        .addr(ram_addr), .wdata(ram_wdata), .we(ram_we), .rdata(ram_rdata)
    );

endmodule

// ==== sim/tiny16_clkgen.sv ====
`timescale 1ns/1ps
module tiny16_clkgen (
    output logic clk,
    output logic nreset
);
    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        nreset = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        nreset = 1'b1;
    end

endmodule

// ==== sim/tb_tiny16.sv ====
`timescale 1ns/1ps
module tb_tiny16
    import tiny16_pkg::*;
();
    logic                 clk;
    logic                 nreset;
    logic                 run;
    logic                 boot_we;
    logic [ram_bits-1:0]  boot_addr;
    logic [word_bits-1:0] boot_data;
    logic [word_bits-1:0] data_in;
    logic                 mem_ready;
    logic                 interrupt;
    logic [word_bits-1:0] address;
    logic [word_bits-1:0] data_out;
    logic                 mem_valid;
    logic                 nwr;
    logic                 hlt;
    logic                 wfi;
    logic                 in_interrupt;

    // header, program, replies, then expected writes in triples
    logic [word_bits-1:0] img [0:255];
    logic [word_bits-1:0] trigger_port;
    int                   prog_count;
    int                   reply_count;
    int                   exp_count;
    int                   reply_base;
    int                   exp_base;
    int                   reply_idx;
    int                   exp_idx;
    logic                 trigger_seen;

    tiny16_clkgen u_clkgen (
        .clk(clk),
        .nreset(nreset)
    );

    tiny16_top DUT (
        .clk(clk), .nreset(nreset), .run(run),
        .boot_we(boot_we), .boot_addr(boot_addr), .boot_data(boot_data),
        .data_in(data_in), .mem_ready(mem_ready), .interrupt(interrupt),
        .address(address), .data_out(data_out), .mem_valid(mem_valid), .nwr(nwr),
        .hlt(hlt), .wfi(wfi), .in_interrupt(in_interrupt)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [word_bits-1:0] expected,
                               input logic [word_bits-1:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] t=%0t %s: expected %h, got %h", $time, name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    // one out cycle against the next expected triple
    task automatic check_write();
        int base;
        base = exp_base + 3 * exp_idx;
        assert (exp_idx < exp_count) else stop_run("output write with none left to expect");
        check_value("address", img[base], address);
        check_value("data_out", img[base + 1], data_out);
        check_value("in_interrupt", {15'd0, img[base + 2][0]}, {15'd0, in_interrupt});
        if (address == trigger_port)
            trigger_seen = 1'b1;
        // handler has taken the interrupt so the line drops before reti
        if (img[base + 2][0])
            interrupt = 1'b0;
        exp_idx++;
    endtask

    initial begin : main
        run = 1'b0;
        boot_we = 1'b0;
        boot_addr = '0;
        boot_data = '0;
        data_in = '0;
        mem_ready = 1'b0;
        interrupt = 1'b0;
        reply_idx = 0;
        exp_idx = 0;
        trigger_seen = 1'b0;
        $readmemh("sim/tiny16_test_input.txt", img);
        trigger_port = img[0];
        prog_count = int'(img[1]);
        reply_count = int'(img[2]);
        exp_count = int'(img[3]);
        reply_base = 4 + prog_count;
        exp_base = reply_base + reply_count;

        wait (nreset === 1'b1);
        // boot load at one word per cycle
        for (int i = 0; i < prog_count; i++) begin
            @(posedge clk);
            #10;
            boot_we = 1'b1;
            boot_addr = i[ram_bits-1:0];
            boot_data = img[4 + i];
        end
        @(posedge clk);
        #10;
        boot_we = 1'b0;
        run = 1'b1;

        wait (hlt === 1'b1);
        @(posedge clk);
        #10;
        assert (exp_idx == exp_count) else stop_run("core halted before all expected writes");
        assert (reply_idx == reply_count)
            else stop_run("core halted with input replies unused");
        assert (!in_interrupt) else stop_run("core halted inside the interrupt handler");
        repeat (20) begin
            @(posedge clk);
            #10;
            assert (!mem_valid) else stop_run("bus cycle started after halt");
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

    // I/O device with a random answer delay
    initial begin : io_device
        int unsigned delay;
        delay = $urandom(32'hb82c_633b);
        forever begin
            @(posedge clk);
            #10;
            if (mem_valid) begin
                if (nwr) begin
                    assert (reply_idx < reply_count)
                        else stop_run("input read with no reply left");
                    data_in = img[reply_base + reply_idx];
                    reply_idx++;
                end else begin
                    check_write();
                end
                delay = $urandom % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #10;
                end
                mem_ready = 1'b1;
                @(posedge clk);
                #10;
                mem_ready = 1'b0;
            end
        end
    end

    initial begin : irq_source
        wait (trigger_seen === 1'b1);
        while (wfi !== 1'b1) begin
            @(posedge clk);
            #10;
        end
        // core must sit in its wfi wait
        repeat (5) begin
            @(posedge clk);
            #10;
            assert (wfi && !in_interrupt && !mem_valid)
                else stop_run("core left the wfi wait early");
        end
        interrupt = 1'b1;
    end

    initial begin : watchdog
        int limit_cycles;
        #1;
        limit_cycles = 200 * prog_count + 2000;
        repeat (limit_cycles) @(posedge clk);
        $display("timeout, core did not reach halt within %0d cycles", limit_cycles);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

endmodule

// ==== sim/tiny16_test_input.txt ====
// header: trigger port, program words, input replies, expected writes
// then program words, replies, and expected writes as address data in_interrupt
00F0 004D 0002 0015
// program, handler at 1, data table from 0x46
2003 561D 4800 A461 A472 A493 A4CD A48B
5424 5425 4456 6146 5616 4457 6247 5617
4458 6848 5618 6949 5619 6C4A 561A F1FA
561A 0024 5614 5613 0021 5614 5613 002A
5614 5613 6888 0022 5614 5613 0029 5614
5613 6488 002C 5614 5613 0024 5613 2002
5614 5613 A4A8 5248 5089 5619 A4BA 4A0A
4C50 4C60 4E09 4E0A 5619 561A 8006 561C
56B3 4200 5618 4000 447C 4600
0010 0020 00F0 00AA 0080 0100 0055
// input replies
8421 9001
// add, sbc, xor, shl, ror, add immediate
0010 1422 0000
0010 F41F 0000
0010 1420 0000
0010 0842 0000
0010 C210 0000
0010 C20F 0000
// branch and jump markers
0010 00AA 0000
0010 00AA 0000
0010 00AA 0000
0010 00AA 0000
0010 00AA 0000
0010 00AA 0000
0010 00AA 0000
0010 00AA 0000
// memory, stack and call
0010 8421 0000
0010 1422 0000
0010 9001 0000
0010 F41F 0000
// trigger, handler, resume
00F0 00AA 0000
0010 0055 0001
0010 0080 0000

// ==== files.f ====
rtl/tiny16_pkg.sv
rtl/tiny16_decode.sv
rtl/tiny16_alu.sv
rtl/tiny16_result.sv
rtl/tiny16_core.sv
rtl/tiny16_ram.sv
rtl/tiny16_top.sv
sim/tiny16_clkgen.sv
sim/tb_tiny16.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_tiny16 -o tb_tiny16_sim &&
out="$(./obj_dir/tb_tiny16_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
